/* vlog.f */
logic/cce_msg_pkg.sv
logic/cce_req_fifo.sv
logic/cce_msg_cached.sv
logic/cce_msg_uncached.sv
logic/cce_msg_router.sv
logic/cce_msg_top.sv
test/cce_msg_properties.sv
test/cce_msg_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cce_msg_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/cce_msg_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for cce_msg_top with random traffic, memory and LCE models
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cce_msg_tb
  import cce_msg_pkg::*;
  ();

  localparam int clk_period_lp = 40;
  localparam int num_txn_lp    = 160;
  localparam int txn_cycles_lp = 40;

  logic clk_i = 1'b0, reset_i;
  cce_mode_e mode_i;
  lce_req_type_e lce_req_type_i;
  lce_id_t lce_req_lce_id_i, mem_cmd_lce_id_o, mem_resp_lce_id_i, lce_cmd_lce_id_o;
  paddr_t lce_req_addr_i, mem_cmd_addr_o, mem_resp_addr_i, lce_cmd_addr_o;
  data_t lce_req_data_i, mem_cmd_data_o, mem_resp_data_i, lce_cmd_data_o;
  mem_cmd_type_e mem_cmd_type_o, mem_resp_type_i;
  lce_cmd_type_e lce_cmd_type_o;
  logic lce_req_v_i, lce_req_ready_o, mem_cmd_v_o, mem_cmd_ready_i;
  logic mem_resp_v_i, mem_resp_yumi_o, lce_cmd_v_o, lce_cmd_ready_i, fence_zero_o;

  // Message entries packed as {type, lce id, addr, data}
  logic [50:0] req_q[$], resp_q[$], exp_cmd_q[$];
  int          due_q[$];
  data_t       mem_model[paddr_t];
  int group_out[8];
  int cycle, sent, target, lce_count, outstanding, max_out, last_due;
  logic send_en, uc_phase, req_taken;

  cce_msg_top #(.max_outstanding_p(4)) dut_i (.*);

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic fail_run(string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // Handshakes seen at the falling edge complete at the next rising edge
  task automatic observe();
    logic [50:0] e;
    data_t d;
    int delay;
    cycle++;
    if (lce_req_v_i && lce_req_ready_o) begin
      req_q.push_back({lce_req_type_i, lce_req_lce_id_i, lce_req_addr_i, lce_req_data_i});
      sent++;
      req_taken = 1'b1;
    end
    if (mem_cmd_v_o && mem_cmd_ready_i) begin
      if (req_q.size() == 0)
        fail_run("memory command with no request waiting");
      e = req_q.pop_front();
      check_value("mem_cmd_type_o", (e[50] == e_req_wr) ? e_mem_wr : e_mem_rd, mem_cmd_type_o);
      check_value("mem_cmd_lce_id_o", e[49:48], mem_cmd_lce_id_o);
      check_value("mem_cmd_addr_o", e[47:32], mem_cmd_addr_o);
      check_value("mem_cmd_data_o", e[31:0], mem_cmd_data_o);
      if (group_out[e[34:32]] != 0)
        fail_run("request issued to a way group that is still pending");
      if (uc_phase && outstanding != 0)
        fail_run("second memory command outstanding in uncached mode");
      group_out[e[34:32]]++;
      outstanding++;
      if (outstanding > max_out)
        max_out = outstanding;
      // In-order memory, reads see all earlier writes
      d = mem_model.exists(e[47:32]) ? mem_model[e[47:32]] : {16'h0, e[47:32]};
      if (e[50] == e_req_wr)
        mem_model[e[47:32]] = e[31:0];
      delay = $urandom_range(1, 8);
      if (cycle + delay > last_due)
        last_due = cycle + delay;
      due_q.push_back(last_due);
      resp_q.push_back({e[50:32], d});
    end
    if (mem_resp_v_i && mem_resp_yumi_o) begin
      e = resp_q.pop_front();
      void'(due_q.pop_front());
      group_out[e[34:32]]--;
      outstanding--;
      exp_cmd_q.push_back({e[50] ? e_cmd_st_done : e_cmd_data, e[49:32],
                           e[50] ? 32'h0 : e[31:0]});
    end
    if (lce_cmd_v_o && lce_cmd_ready_i) begin
      if (exp_cmd_q.size() == 0)
        fail_run("LCE command with no memory response behind it");
      e = exp_cmd_q.pop_front();
      check_value("lce_cmd_type_o", e[50], lce_cmd_type_o);
      check_value("lce_cmd_lce_id_o", e[49:48], lce_cmd_lce_id_o);
      check_value("lce_cmd_addr_o", e[47:32], lce_cmd_addr_o);
      check_value("lce_cmd_data_o", e[31:0], lce_cmd_data_o);
      lce_count++;
    end
  endtask

  task automatic drive();
    if (!lce_req_v_i || req_taken) begin
      lce_req_v_i      = send_en && (sent < target) && ($urandom_range(0, 3) != 0);
      lce_req_type_i   = lce_req_type_e'($urandom_range(0, 1));
      lce_req_lce_id_i = lce_id_t'($urandom_range(0, 3));
      lce_req_addr_i   = paddr_t'($urandom_range(0, 31));
      lce_req_data_i   = $urandom();
    end
    req_taken       = 1'b0;
    mem_cmd_ready_i = ($urandom_range(0, 2) != 0);
    lce_cmd_ready_i = ($urandom_range(0, 2) != 0);
    mem_resp_v_i    = (resp_q.size() != 0) && (cycle >= due_q[0]);
    if (resp_q.size() != 0) begin
      mem_resp_type_i = mem_cmd_type_e'(resp_q[0][50]);
      {mem_resp_lce_id_i, mem_resp_addr_i, mem_resp_data_i} = resp_q[0][49:0];
    end
  endtask

  // Send n requests, switch mode_i while they drain, then wait for the fence
  task automatic run_phase(logic uc, int n, cce_mode_e next_mode);
    int idle_cycles;
    uc_phase = uc;
    max_out  = 0;
    target   = sent + n;
    send_en  = 1'b1;
    while (sent < target)
      @(posedge clk_i);
    #1 send_en = 1'b0;
    mode_i = next_mode;
    // The last request may still wait one idle cycle in the FIFO
    idle_cycles = 0;
    while (idle_cycles < 2) begin
      @(negedge clk_i);
      idle_cycles = fence_zero_o ? idle_cycles + 1 : 0;
    end
    @(posedge clk_i);
    check_value("lce command count", sent, lce_count);
    if (!uc && max_out < 2)
      fail_run("no overlap of memory commands in cached mode");
    repeat (2) @(posedge clk_i);
  endtask

  initial begin
    #(num_txn_lp * txn_cycles_lp * clk_period_lp);
    $display("Error: watchdog expired before all transactions drained");
    $display("*** FAILED ***");
    $fatal(1);
  end

  initial begin
    {reset_i, lce_req_v_i, mem_cmd_ready_i, mem_resp_v_i, lce_cmd_ready_i} = 5'b10000;
    lce_req_type_i = e_req_rd;
    {lce_req_lce_id_i, lce_req_addr_i, lce_req_data_i} = '0;
    mem_resp_type_i = e_mem_rd;
    {mem_resp_lce_id_i, mem_resp_addr_i, mem_resp_data_i} = '0;
    mode_i = e_cce_mode_normal;
    {send_en, uc_phase, req_taken} = 3'b000;
    {cycle, sent, target, lce_count, outstanding, max_out, last_due} = '0;
    group_out = '{8{0}};
    repeat (2) @(posedge clk_i);
    #1 reset_i = 1'b0;
    @(negedge clk_i);
    check_value("fence_zero_o", 1, fence_zero_o);
    run_phase(1'b0, 60, e_cce_mode_uncached);
    run_phase(1'b1, 60, e_cce_mode_normal);
    run_phase(1'b0, 40, e_cce_mode_normal);
    if (dut_i.router_i.props_i.fail_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Model loop
  initial begin
    void'($urandom(32'h757160e5));
    @(negedge reset_i);
    forever begin
      @(negedge clk_i);
      observe();
      @(posedge clk_i);
      #1 drive();
    end
  end

endmodule

/* test/cce_msg_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake and mode switch assertions, bound into the router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cce_msg_properties
  import cce_msg_pkg::*;
  (input clk_i, input reset_i, input fence_zero_o, input cce_mode_e mode_r
   , input mem_cmd_v_o, input mem_cmd_ready_i, input [50:0] mem_cmd_bits
   , input lce_cmd_v_o, input lce_cmd_ready_i, input [50:0] lce_cmd_bits
   , input req_v_i, input req_yumi_o, input mem_resp_v_i, input mem_resp_yumi_o
  );

  int fail_count = 0;

  mem_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_bits))
    else begin
      $error("mem_cmd dropped or changed before ready");
      fail_count++;
    end

  lce_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_cmd_v_o && !lce_cmd_ready_i |=> lce_cmd_v_o && $stable(lce_cmd_bits))
    else begin
      $error("lce_cmd dropped or changed before ready");
      fail_count++;
    end

  yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i)
    (!req_yumi_o || req_v_i) && (!mem_resp_yumi_o || mem_resp_v_i))
    else begin
      $error("yumi raised without valid");
      fail_count++;
    end

  mode_at_fence: assert property (@(posedge clk_i) disable iff (reset_i)
    !$stable(mode_r) |-> $past(fence_zero_o))
    else begin
      $error("mode changed while transactions were outstanding");
      fail_count++;
    end

endmodule

bind cce_msg_router cce_msg_properties props_i (
  .clk_i, .reset_i, .fence_zero_o, .mode_r
  , .mem_cmd_v_o, .mem_cmd_ready_i
  , .mem_cmd_bits({mem_cmd_type_o, mem_cmd_lce_id_o, mem_cmd_addr_o, mem_cmd_data_o})
  , .lce_cmd_v_o, .lce_cmd_ready_i
  , .lce_cmd_bits({lce_cmd_type_o, lce_cmd_lce_id_o, lce_cmd_addr_o, lce_cmd_data_o})
  , .req_v_i, .req_yumi_o, .mem_resp_v_i, .mem_resp_yumi_o
);

/* logic/cce_msg_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CCE message unit top, request FIFO feeding the router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cce_msg_top
  import cce_msg_pkg::*;
  #(parameter int max_outstanding_p = 4)
  (input                   clk_i
   , input                 reset_i
   , input cce_mode_e      mode_i

   , input lce_req_type_e  lce_req_type_i
   , input lce_id_t        lce_req_lce_id_i
   , input paddr_t         lce_req_addr_i
   , input data_t          lce_req_data_i
   , input                 lce_req_v_i
   , output logic          lce_req_ready_o

   , output mem_cmd_type_e mem_cmd_type_o
   , output lce_id_t       mem_cmd_lce_id_o
   , output paddr_t        mem_cmd_addr_o
   , output data_t         mem_cmd_data_o
   , output logic          mem_cmd_v_o
   , input                 mem_cmd_ready_i

   , input mem_cmd_type_e  mem_resp_type_i
   , input lce_id_t        mem_resp_lce_id_i
   , input paddr_t         mem_resp_addr_i
   , input data_t          mem_resp_data_i
   , input                 mem_resp_v_i
   , output logic          mem_resp_yumi_o

   , output lce_cmd_type_e lce_cmd_type_o
   , output lce_id_t       lce_cmd_lce_id_o
   , output paddr_t        lce_cmd_addr_o
   , output data_t         lce_cmd_data_o
   , output logic          lce_cmd_v_o
   , input                 lce_cmd_ready_i

   , output logic          fence_zero_o
  );

  // FIFO head
  lce_req_type_e head_type;
  lce_id_t       head_lce_id;
  paddr_t        head_addr;
  data_t         head_data;
  logic          head_v, head_yumi;

  cce_req_fifo req_fifo_i (
    .clk_i, .reset_i
    , .type_i(lce_req_type_i), .lce_id_i(lce_req_lce_id_i)
    , .addr_i(lce_req_addr_i), .data_i(lce_req_data_i)
    , .v_i(lce_req_v_i), .ready_o(lce_req_ready_o)
    , .type_o(head_type), .lce_id_o(head_lce_id)
    , .addr_o(head_addr), .data_o(head_data)
    , .v_o(head_v), .yumi_i(head_yumi)
  );

  cce_msg_router #(.max_outstanding_p(max_outstanding_p)) router_i (
    .clk_i, .reset_i, .mode_i
    , .req_type_i(head_type), .req_lce_id_i(head_lce_id)
    , .req_addr_i(head_addr), .req_data_i(head_data)
    , .req_v_i(head_v), .req_yumi_o(head_yumi)
    , .mem_cmd_type_o, .mem_cmd_lce_id_o, .mem_cmd_addr_o, .mem_cmd_data_o
    , .mem_cmd_v_o, .mem_cmd_ready_i
    , .mem_resp_type_i, .mem_resp_lce_id_i, .mem_resp_addr_i, .mem_resp_data_i
    , .mem_resp_v_i, .mem_resp_yumi_o
    , .lce_cmd_type_o, .lce_cmd_lce_id_o, .lce_cmd_addr_o, .lce_cmd_data_o
    , .lce_cmd_v_o, .lce_cmd_ready_i
    , .fence_zero_o
  );

endmodule

/* logic/cce_msg_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode register and steering of all channels to the active handler
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cce_msg_router
  import cce_msg_pkg::*;
  #(parameter int max_outstanding_p = 4)
  (input                   clk_i
   , input                 reset_i
   , input cce_mode_e      mode_i

   , input lce_req_type_e  req_type_i
   , input lce_id_t        req_lce_id_i
   , input paddr_t         req_addr_i
   , input data_t          req_data_i
   , input                 req_v_i
   , output logic          req_yumi_o

   , output mem_cmd_type_e mem_cmd_type_o
   , output lce_id_t       mem_cmd_lce_id_o
   , output paddr_t        mem_cmd_addr_o
   , output data_t         mem_cmd_data_o
   , output logic          mem_cmd_v_o
   , input                 mem_cmd_ready_i

   , input mem_cmd_type_e  mem_resp_type_i
   , input lce_id_t        mem_resp_lce_id_i
   , input paddr_t         mem_resp_addr_i
   , input data_t          mem_resp_data_i
   , input                 mem_resp_v_i
   , output logic          mem_resp_yumi_o

   , output lce_cmd_type_e lce_cmd_type_o
   , output lce_id_t       lce_cmd_lce_id_o
   , output paddr_t        lce_cmd_addr_o
   , output data_t         lce_cmd_data_o
   , output logic          lce_cmd_v_o
   , input                 lce_cmd_ready_i

   , output logic          fence_zero_o
  );

  cce_mode_e mode_r;
  logic      uc;

  // Handler outputs, c_ for cached and u_ for uncached
  mem_cmd_type_e c_mem_cmd_type, u_mem_cmd_type;
  lce_cmd_type_e c_lce_cmd_type, u_lce_cmd_type;
  lce_id_t       c_mem_cmd_lce_id, u_mem_cmd_lce_id, c_lce_cmd_lce_id, u_lce_cmd_lce_id;
  paddr_t        c_mem_cmd_addr, u_mem_cmd_addr, c_lce_cmd_addr, u_lce_cmd_addr;
  data_t         c_mem_cmd_data, u_mem_cmd_data, c_lce_cmd_data, u_lce_cmd_data;
  logic c_req_yumi, u_req_yumi, c_mem_resp_yumi, u_mem_resp_yumi;
  logic c_mem_cmd_v, u_mem_cmd_v, c_lce_cmd_v, u_lce_cmd_v;
  logic c_idle, u_idle;

  assign uc           = (mode_r == e_cce_mode_uncached);
  assign fence_zero_o = c_idle & u_idle;

  // Switch only when drained and no request moves this cycle
  always_ff @(posedge clk_i) begin
    if (reset_i)
      mode_r <= e_cce_mode_normal;
    else if (fence_zero_o & ~req_yumi_o)
      mode_r <= mode_i;
  end

  cce_msg_cached #(.max_outstanding_p(max_outstanding_p)) cached_i (
    .clk_i, .reset_i
    , .lce_req_type_i(req_type_i), .lce_req_lce_id_i(req_lce_id_i)
    , .lce_req_addr_i(req_addr_i), .lce_req_data_i(req_data_i)
    , .lce_req_v_i(req_v_i & ~uc), .lce_req_yumi_o(c_req_yumi)
    , .mem_cmd_type_o(c_mem_cmd_type), .mem_cmd_lce_id_o(c_mem_cmd_lce_id)
    , .mem_cmd_addr_o(c_mem_cmd_addr), .mem_cmd_data_o(c_mem_cmd_data)
    , .mem_cmd_v_o(c_mem_cmd_v), .mem_cmd_ready_i(mem_cmd_ready_i & ~uc)
    , .mem_resp_type_i, .mem_resp_lce_id_i, .mem_resp_addr_i, .mem_resp_data_i
    , .mem_resp_v_i(mem_resp_v_i & ~uc), .mem_resp_yumi_o(c_mem_resp_yumi)
    , .lce_cmd_type_o(c_lce_cmd_type), .lce_cmd_lce_id_o(c_lce_cmd_lce_id)
    , .lce_cmd_addr_o(c_lce_cmd_addr), .lce_cmd_data_o(c_lce_cmd_data)
    , .lce_cmd_v_o(c_lce_cmd_v), .lce_cmd_ready_i(lce_cmd_ready_i & ~uc)
    , .idle_o(c_idle)
  );

  cce_msg_uncached uncached_i (
    .clk_i, .reset_i
    , .lce_req_type_i(req_type_i), .lce_req_lce_id_i(req_lce_id_i)
    , .lce_req_addr_i(req_addr_i), .lce_req_data_i(req_data_i)
    , .lce_req_v_i(req_v_i & uc), .lce_req_yumi_o(u_req_yumi)
    , .mem_cmd_type_o(u_mem_cmd_type), .mem_cmd_lce_id_o(u_mem_cmd_lce_id)
    , .mem_cmd_addr_o(u_mem_cmd_addr), .mem_cmd_data_o(u_mem_cmd_data)
    , .mem_cmd_v_o(u_mem_cmd_v), .mem_cmd_ready_i(mem_cmd_ready_i & uc)
    , .mem_resp_type_i, .mem_resp_lce_id_i, .mem_resp_addr_i, .mem_resp_data_i
    , .mem_resp_v_i(mem_resp_v_i & uc), .mem_resp_yumi_o(u_mem_resp_yumi)
    , .lce_cmd_type_o(u_lce_cmd_type), .lce_cmd_lce_id_o(u_lce_cmd_lce_id)
    , .lce_cmd_addr_o(u_lce_cmd_addr), .lce_cmd_data_o(u_lce_cmd_data)
    , .lce_cmd_v_o(u_lce_cmd_v), .lce_cmd_ready_i(lce_cmd_ready_i & uc)
    , .idle_o(u_idle)
  );

  // Output select
  assign req_yumi_o       = uc ? u_req_yumi       : c_req_yumi;
  assign mem_resp_yumi_o  = uc ? u_mem_resp_yumi  : c_mem_resp_yumi;
  assign mem_cmd_type_o   = uc ? u_mem_cmd_type   : c_mem_cmd_type;
  assign mem_cmd_lce_id_o = uc ? u_mem_cmd_lce_id : c_mem_cmd_lce_id;
  assign mem_cmd_addr_o   = uc ? u_mem_cmd_addr   : c_mem_cmd_addr;
  assign mem_cmd_data_o   = uc ? u_mem_cmd_data   : c_mem_cmd_data;
  assign mem_cmd_v_o      = uc ? u_mem_cmd_v      : c_mem_cmd_v;
  assign lce_cmd_type_o   = uc ? u_lce_cmd_type   : c_lce_cmd_type;
  assign lce_cmd_lce_id_o = uc ? u_lce_cmd_lce_id : c_lce_cmd_lce_id;
  assign lce_cmd_addr_o   = uc ? u_lce_cmd_addr   : c_lce_cmd_addr;
  assign lce_cmd_data_o   = uc ? u_lce_cmd_data   : c_lce_cmd_data;
  assign lce_cmd_v_o      = uc ? u_lce_cmd_v      : c_lce_cmd_v;

endmodule

/* logic/cce_msg_uncached.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Uncached-mode handler, one memory transaction at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cce_msg_uncached
  import cce_msg_pkg::*;
  (input                   clk_i
   , input                 reset_i

   , input lce_req_type_e  lce_req_type_i
   , input lce_id_t        lce_req_lce_id_i
   , input paddr_t         lce_req_addr_i
   , input data_t          lce_req_data_i
   , input                 lce_req_v_i
   , output logic          lce_req_yumi_o

   , output mem_cmd_type_e mem_cmd_type_o
   , output lce_id_t       mem_cmd_lce_id_o
   , output paddr_t        mem_cmd_addr_o
   , output data_t         mem_cmd_data_o
   , output logic          mem_cmd_v_o
   , input                 mem_cmd_ready_i

   , input mem_cmd_type_e  mem_resp_type_i
   , input lce_id_t        mem_resp_lce_id_i
   , input paddr_t         mem_resp_addr_i
   , input data_t          mem_resp_data_i
   , input                 mem_resp_v_i
   , output logic          mem_resp_yumi_o

   , output lce_cmd_type_e lce_cmd_type_o
   , output lce_id_t       lce_cmd_lce_id_o
   , output paddr_t        lce_cmd_addr_o
   , output data_t         lce_cmd_data_o
   , output logic          lce_cmd_v_o
   , input                 lce_cmd_ready_i

   , output logic          idle_o
  );

  typedef enum logic {
    e_uc_ready,
    e_uc_wait_resp
  } uc_state_e;

  uc_state_e state_r;
  logic      mem_cmd_free, lce_cmd_free;

  assign mem_cmd_free = ~mem_cmd_v_o | mem_cmd_ready_i;
  assign lce_cmd_free = ~lce_cmd_v_o | lce_cmd_ready_i;

  // Only the one awaited response is taken
  assign mem_resp_yumi_o = mem_resp_v_i & lce_cmd_free & (state_r == e_uc_wait_resp);
  assign lce_req_yumi_o  = lce_req_v_i & ~mem_resp_yumi_o & mem_cmd_free
                           & (state_r == e_uc_ready);

  // Idle once the last LCE command has left too
  assign idle_o = (state_r == e_uc_ready) & ~lce_cmd_v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= e_uc_ready;
      mem_cmd_v_o <= 1'b0;
      lce_cmd_v_o <= 1'b0;
    end else begin
      unique case (state_r)
        e_uc_ready:     if (lce_req_yumi_o) state_r <= e_uc_wait_resp;
        e_uc_wait_resp: if (mem_resp_yumi_o) state_r <= e_uc_ready;
        default:        state_r <= e_uc_ready;
      endcase

      if (lce_req_yumi_o)
        mem_cmd_v_o <= 1'b1;
      else if (mem_cmd_ready_i)
        mem_cmd_v_o <= 1'b0;

      if (mem_resp_yumi_o)
        lce_cmd_v_o <= 1'b1;
      else if (lce_cmd_ready_i)
        lce_cmd_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      mem_cmd_type_o   <= (lce_req_type_i == e_req_wr) ? e_mem_wr : e_mem_rd;
      mem_cmd_lce_id_o <= lce_req_lce_id_i;
      mem_cmd_addr_o   <= lce_req_addr_i;
      mem_cmd_data_o   <= lce_req_data_i;
    end
    if (mem_resp_yumi_o) begin
      lce_cmd_type_o   <= (mem_resp_type_i == e_mem_wr) ? e_cmd_st_done : e_cmd_data;
      lce_cmd_lce_id_o <= mem_resp_lce_id_i;
      lce_cmd_addr_o   <= mem_resp_addr_i;
      lce_cmd_data_o   <= (mem_resp_type_i == e_mem_wr) ? '0 : mem_resp_data_i;
    end
  end

endmodule

/* logic/cce_msg_cached.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cached-mode handler, several memory transactions in flight
// Guarded by a pending bit per way group and an outstanding counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cce_msg_cached
  import cce_msg_pkg::*;
  #(parameter int max_outstanding_p = 4)
  (input                   clk_i
   , input                 reset_i

   , input lce_req_type_e  lce_req_type_i
   , input lce_id_t        lce_req_lce_id_i
   , input paddr_t         lce_req_addr_i
   , input data_t          lce_req_data_i
   , input                 lce_req_v_i
   , output logic          lce_req_yumi_o

   , output mem_cmd_type_e mem_cmd_type_o
   , output lce_id_t       mem_cmd_lce_id_o
   , output paddr_t        mem_cmd_addr_o
   , output data_t         mem_cmd_data_o
   , output logic          mem_cmd_v_o
   , input                 mem_cmd_ready_i

   , input mem_cmd_type_e  mem_resp_type_i
   , input lce_id_t        mem_resp_lce_id_i
   , input paddr_t         mem_resp_addr_i
   , input data_t          mem_resp_data_i
   , input                 mem_resp_v_i
   , output logic          mem_resp_yumi_o

   , output lce_cmd_type_e lce_cmd_type_o
   , output lce_id_t       lce_cmd_lce_id_o
   , output paddr_t        lce_cmd_addr_o
   , output data_t         lce_cmd_data_o
   , output logic          lce_cmd_v_o
   , input                 lce_cmd_ready_i

   , output logic          idle_o
  );

  localparam int num_groups_lp = 2 ** $bits(way_group_t);
  localparam int cnt_width_lp  = $clog2(max_outstanding_p + 1);

  logic [num_groups_lp-1:0] pending_r;
  logic [cnt_width_lp-1:0]  count_r;
  way_group_t               req_group, resp_group;
  logic mem_cmd_free, lce_cmd_free, lce_cmd_done;

  assign req_group  = lce_req_addr_i[$bits(way_group_t)-1:0];
  assign resp_group = mem_resp_addr_i[$bits(way_group_t)-1:0];

  // Output registers free up when empty or draining this cycle
  assign mem_cmd_free = ~mem_cmd_v_o | mem_cmd_ready_i;
  assign lce_cmd_free = ~lce_cmd_v_o | lce_cmd_ready_i;
  assign lce_cmd_done = lce_cmd_v_o & lce_cmd_ready_i;

  // Responses win over new requests
  assign mem_resp_yumi_o = mem_resp_v_i & lce_cmd_free;
  assign lce_req_yumi_o  = lce_req_v_i & ~mem_resp_yumi_o & mem_cmd_free
                           & ~pending_r[req_group]
                           & (count_r < cnt_width_lp'(max_outstanding_p));

  // A transaction ends with its LCE command handshake
  assign idle_o = (count_r == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r   <= '0;
      count_r     <= '0;
      mem_cmd_v_o <= 1'b0;
      lce_cmd_v_o <= 1'b0;
    end else begin
      if (lce_req_yumi_o)
        pending_r[req_group] <= 1'b1;
      if (mem_resp_yumi_o)
        pending_r[resp_group] <= 1'b0;

      unique case ({lce_req_yumi_o, lce_cmd_done})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase

      if (lce_req_yumi_o)
        mem_cmd_v_o <= 1'b1;
      else if (mem_cmd_ready_i)
        mem_cmd_v_o <= 1'b0;

      if (mem_resp_yumi_o)
        lce_cmd_v_o <= 1'b1;
      else if (lce_cmd_ready_i)
        lce_cmd_v_o <= 1'b0;
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      mem_cmd_type_o   <= (lce_req_type_i == e_req_wr) ? e_mem_wr : e_mem_rd;
      mem_cmd_lce_id_o <= lce_req_lce_id_i;
      mem_cmd_addr_o   <= lce_req_addr_i;
      mem_cmd_data_o   <= lce_req_data_i;
    end
    if (mem_resp_yumi_o) begin
      lce_cmd_type_o   <= (mem_resp_type_i == e_mem_wr) ? e_cmd_st_done : e_cmd_data;
      lce_cmd_lce_id_o <= mem_resp_lce_id_i;
      lce_cmd_addr_o   <= mem_resp_addr_i;
      lce_cmd_data_o   <= (mem_resp_type_i == e_mem_wr) ? '0 : mem_resp_data_i;
    end
  end

endmodule

/* logic/cce_req_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry LCE request buffer, ready&valid in and valid->yumi out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cce_req_fifo
  import cce_msg_pkg::*;
  (input                 clk_i
   , input               reset_i

   , input lce_req_type_e type_i
   , input lce_id_t       lce_id_i
   , input paddr_t        addr_i
   , input data_t         data_i
   , input                v_i
   , output logic         ready_o

   , output lce_req_type_e type_o
   , output lce_id_t       lce_id_o
   , output paddr_t        addr_o
   , output data_t         data_o
   , output logic          v_o
   , input                 yumi_i
  );

  lce_req_type_e type_mem [2];
  lce_id_t       lce_id_mem [2];
  paddr_t        addr_mem [2];
  data_t         data_mem [2];

  logic       wr_ptr_r, rd_ptr_r;
  logic [1:0] count_r;
  logic       enq, deq;

  // Stays low while full, even if the head leaves this cycle
  assign ready_o = (count_r != 2'd2);
  assign v_o     = (count_r != 2'd0);
  assign enq     = v_i & ready_o;
  assign deq     = yumi_i;

  assign type_o   = type_mem[rd_ptr_r];
  assign lce_id_o = lce_id_mem[rd_ptr_r];
  assign addr_o   = addr_mem[rd_ptr_r];
  assign data_o   = data_mem[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (enq) begin
      type_mem[wr_ptr_r]   <= type_i;
      lce_id_mem[wr_ptr_r] <= lce_id_i;
      addr_mem[wr_ptr_r]   <= addr_i;
      data_mem[wr_ptr_r]   <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      unique case ({enq, deq})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

/* logic/cce_msg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field widths and message encodings for the CCE message unit
// Imported by the RTL and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cce_msg_pkg;

  // Physical block address and data word
  typedef logic [15:0] paddr_t;
  typedef logic [31:0] data_t;

  // Requesting LCE number
  typedef logic [1:0] lce_id_t;

  // Low address bits, one pending bit each
  typedef logic [2:0] way_group_t;

  typedef enum logic {
    e_cce_mode_normal,
    e_cce_mode_uncached
  } cce_mode_e;

  typedef enum logic {
    e_req_rd,
    e_req_wr
  } lce_req_type_e;

  typedef enum logic {
    e_mem_rd,
    e_mem_wr
  } mem_cmd_type_e;

  // Data returns read data, st_done acks a store
  typedef enum logic {
    e_cmd_data,
    e_cmd_st_done
  } lce_cmd_type_e;

endpackage
